// File: Bender.yml
package:
  name: dw_read_downsizer

sources:
  - common/dwc_pkg.sv
  - logic/ar_dispatch.sv
  - read_unit/read_unit.sv
  - logic/ar_arbiter.sv
  - logic/r_router.sv
  - logic/dw_read_downsizer.sv
  - target: test
    files:
      - dv/dw_read_downsizer_sva.sv
      - dv/tb_dw_read_downsizer.sv

// File: build.f
common/dwc_pkg.sv
logic/ar_dispatch.sv
read_unit/read_unit.sv
logic/ar_arbiter.sv
logic/r_router.sv
logic/dw_read_downsizer.sv
dv/dw_read_downsizer_sva.sv
dv/tb_dw_read_downsizer.sv

// File: common/dwc_pkg.sv
`default_nettype none

package dwc_pkg;

  // Byte lanes per beat on the wide and the narrow port
  localparam int unsigned UpDataBytes = 8;
  localparam int unsigned DnDataBytes = 4;

  // log2 of the lane counts, as transfer size codes
  localparam int unsigned UpMaxSize = 3;
  localparam int unsigned DnMaxSize = 2;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned IdWidth   = 4;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [7:0]           len_t;
  typedef logic [2:0]           size_t;
  typedef logic [1:0]           resp_t;

  // Encoding order doubles as severity order
  typedef enum logic [1:0] {
    RESP_OKAY,
    RESP_EXOKAY,
    RESP_SLVERR,
    RESP_DECERR
  } resp_e;

  // Read request, used on both ports
  typedef struct packed {
    id_t   id;
    addr_t addr;
    len_t  len;
    size_t size;
  } ar_req_t;

  typedef struct packed {
    id_t                      id;
    logic [8*UpDataBytes-1:0] data;
    resp_t                    resp;
    logic                     last;
  } up_r_t;

  typedef struct packed {
    id_t                      id;
    logic [8*DnDataBytes-1:0] data;
    resp_t                    resp;
    logic                     last;
  } dn_r_t;

  typedef enum logic [1:0] {
    UNIT_IDLE,
    UNIT_PASSTHROUGH,
    UNIT_DOWNSIZE
  } unit_state_e;

endpackage

`default_nettype wire

// File: dv/dw_read_downsizer_sva.sv
`default_nettype none

module dw_read_downsizer_sva #(
  parameter int unsigned NumUnits = 4
) (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        dn_ar_valid_i,
  input dwc_pkg::ar_req_t            dn_ar_i,
  input logic                        dn_ar_ready_i,
  input logic                        dn_r_valid_i,
  input dwc_pkg::dn_r_t              dn_r_i,
  input logic [NumUnits-1:0]         unit_busy_i,
  input dwc_pkg::id_t [NumUnits-1:0] unit_id_i,
  input logic                        up_r_valid_i,
  input dwc_pkg::up_r_t              up_r_i,
  input logic                        up_r_ready_i
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [NumUnits-1:0] owner;

  always_comb begin
    for (int i = 0; i < NumUnits; i++) begin
      owner[i] = unit_busy_i[i] && (unit_id_i[i] == dn_r_i.id);
    end
  end

  dn_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dn_ar_valid_i && !dn_ar_ready_i |=> dn_ar_valid_i && $stable(dn_ar_i))
    else $error("Downstream request dropped or changed while stalled");

  // A response for an id that no unit holds would be lost
  dn_r_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dn_r_valid_i |-> |owner)
    else $error("Downstream response id matches no busy unit");

  up_r_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    up_r_valid_i && !up_r_ready_i |=> up_r_valid_i && $stable(up_r_i))
    else $error("Upstream response dropped or changed while stalled");

endmodule

bind dw_read_downsizer dw_read_downsizer_sva #(
  .NumUnits (NumUnits)
) dw_read_downsizer_sva_i (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .dn_ar_valid_i (dn_ar_valid_o),
  .dn_ar_i       (dn_ar_o),
  .dn_ar_ready_i (dn_ar_ready_i),
  .dn_r_valid_i  (dn_r_valid_i),
  .dn_r_i        (dn_r_i),
  .unit_busy_i   (unit_busy),
  .unit_id_i     (unit_id),
  .up_r_valid_i  (up_r_valid_o),
  .up_r_i        (up_r_o),
  .up_r_ready_i  (up_r_ready_i)
);

`default_nettype wire

// File: dv/tb_dw_read_downsizer.sv
`default_nettype none

module tb_dw_read_downsizer;

  timeunit 1ns;
  timeprecision 1ps;

  import dwc_pkg::*;

  localparam int unsigned NumUnits   = 4;
  localparam int unsigned NumReads   = 200;
  localparam int unsigned MaxCycles  = NumReads * 80;
  localparam logic [31:0] Seed       = 32'hc92faffe;
  localparam int unsigned ErrAddrBit = 12;

  logic    clk_i;
  logic    rst_ni;
  logic    up_ar_valid_i;
  ar_req_t up_ar_i;
  logic    up_ar_ready_o;
  logic    up_r_valid_o;
  up_r_t   up_r_o;
  logic    up_r_ready_i;
  logic    dn_ar_valid_o;
  ar_req_t dn_ar_o;
  logic    dn_ar_ready_i;
  logic    dn_r_valid_i;
  dn_r_t   dn_r_i;
  logic    dn_r_ready_o;

  // Issued reads per id in issue order and the beat count of each head
  ar_req_t exp_q [1<<IdWidth][$];
  int      beat_cnt [1<<IdWidth];

  // Accepted downstream bursts and the one being answered
  ar_req_t pend_q [$];
  ar_req_t act_req;
  int      act_beat;
  logic    act_on = 1'b0;

  int errors     = 0;
  int checks     = 0;
  int reads_done = 0;
  int dn_reqs    = 0;
  int cycles     = 0;

  dw_read_downsizer #(
    .NumUnits (NumUnits)
  ) dw_read_downsizer_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .up_ar_valid_i (up_ar_valid_i),
    .up_ar_i       (up_ar_i),
    .up_ar_ready_o (up_ar_ready_o),
    .up_r_valid_o  (up_r_valid_o),
    .up_r_o        (up_r_o),
    .up_r_ready_i  (up_r_ready_i),
    .dn_ar_valid_o (dn_ar_valid_o),
    .dn_ar_o       (dn_ar_o),
    .dn_ar_ready_i (dn_ar_ready_i),
    .dn_r_valid_i  (dn_r_valid_i),
    .dn_r_i        (dn_r_i),
    .dn_r_ready_o  (dn_r_ready_o)
  );

  always #5ns clk_i = !clk_i;

  // Memory content depends on every address bit
  function automatic logic [7:0] mem_byte(input addr_t a);
    return a[7:0] ^ {a[14:8], a[15]} ^ {a[21:16], a[23:22]} ^ a[31:24] ^ 8'h5a;
  endfunction

  // Wide beat as the upstream port must see it
  function automatic up_r_t expected_beat(input ar_req_t req, input int beat);
    up_r_t r;
    addr_t a;
    addr_t ba;
    int    nb;
    int    off;
    nb     = 1 << req.size;
    a      = req.addr + addr_t'(beat * nb);
    off    = int'(a[2:0]);
    r.id   = req.id;
    r.data = '0;
    r.resp = RESP_OKAY;
    r.last = (beat == int'(req.len));
    for (int l = 0; l < UpDataBytes; l++) begin
      if ((l >= off) && (l < off + nb)) begin
        ba = {a[31:3], 3'b000} + addr_t'(l);
        r.data[8*l +: 8] = mem_byte(ba);
        if (ba[ErrAddrBit]) begin
          r.resp = RESP_SLVERR;
        end
      end
    end
    return r;
  endfunction

  // Full narrow word answered by the memory model
  function automatic dn_r_t narrow_beat(input ar_req_t req, input int beat);
    dn_r_t r;
    addr_t a;
    a    = req.addr + addr_t'(beat << req.size);
    r.id = req.id;
    for (int b = 0; b < DnDataBytes; b++) begin
      r.data[8*b +: 8] = mem_byte({a[31:2], 2'b00} + addr_t'(b));
    end
    r.resp = a[ErrAddrBit] ? RESP_SLVERR : RESP_OKAY;
    r.last = (beat == int'(req.len));
    return r;
  endfunction

  task automatic check_equal(input logic [63:0] got, input logic [63:0] want,
                             input string what);
    checks++;
    if (got !== want) begin
      errors++;
      $display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, want);
    end
  endtask

  task automatic print_counts();
    $display("Reads done: %0d of %0d, checks: %0d, errors: %0d",
             reads_done, NumReads, checks, errors);
  endtask

  // Upstream requests
  initial begin
    ar_req_t req;
    void'($urandom(Seed));
    clk_i         = 1'b0;
    rst_ni        = 1'b0;
    up_ar_valid_i = 1'b0;
    up_ar_i       = '0;
    up_r_ready_i  = 1'b0;
    dn_ar_ready_i = 1'b0;
    dn_r_valid_i  = 1'b0;
    dn_r_i        = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (int n = 0; n < NumReads; n++) begin
      req.id   = id_t'($urandom_range(0, 7));
      req.size = size_t'($urandom_range(0, 3));
      req.len  = len_t'($urandom_range(0, 15));
      req.addr = addr_t'($urandom) & ~((addr_t'(1) << req.size) - addr_t'(1));
      up_ar_valid_i = 1'b1;
      up_ar_i       = req;
      @(negedge clk_i);
      while (!up_ar_ready_o) @(negedge clk_i);
      exp_q[req.id].push_back(req);
      @(posedge clk_i);
      #1;
      up_ar_valid_i = 1'b0;
      repeat ($urandom_range(0, 2)) begin
        @(posedge clk_i);
        #1;
      end
    end
    while (reads_done < NumReads) @(negedge clk_i);
    repeat (10) @(negedge clk_i);
    check_equal(dn_reqs, NumReads, "downstream request count");
    check_equal(pend_q.size() + int'(act_on), 0, "bursts left in memory model");
    print_counts();
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Upstream responses against the scoreboard
  initial begin
    up_r_t want;
    id_t   id;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      if (up_r_valid_o && up_r_ready_i) begin
        id = up_r_o.id;
        if (exp_q[id].size() == 0) begin
          errors++;
          $display("Upstream beat at %0t carries id %0d with no read outstanding", $time, id);
        end else begin
          want = expected_beat(exp_q[id][0], beat_cnt[id]);
          check_equal(up_r_o.data, want.data,
                      $sformatf("data of id %0d beat %0d", id, beat_cnt[id]));
          check_equal(up_r_o.resp, want.resp,
                      $sformatf("resp of id %0d beat %0d", id, beat_cnt[id]));
          check_equal(up_r_o.last, want.last,
                      $sformatf("last of id %0d beat %0d", id, beat_cnt[id]));
          if (want.last) begin
            void'(exp_q[id].pop_front());
            beat_cnt[id] = 0;
            reads_done++;
          end else begin
            beat_cnt[id]++;
          end
        end
      end
      @(posedge clk_i);
      #1;
      up_r_ready_i = ($urandom_range(0, 3) != 0);
    end
  end

  // Downstream memory that reorders bursts of different ids
  initial begin
    ar_req_t dreq;
    ar_req_t head;
    logic    r_taken;
    int      pick;
    int      first;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      r_taken = dn_r_valid_i && dn_r_ready_o;
      if (dn_ar_valid_o && dn_ar_ready_i) begin
        dn_reqs++;
        dreq = dn_ar_o;
        if (exp_q[dreq.id].size() == 0) begin
          errors++;
          $display("Downstream request at %0t has id %0d, which no issued read has",
                   $time, dreq.id);
        end else begin
          head = exp_q[dreq.id][0];
          check_equal(dreq.addr, head.addr, "downstream addr");
          if (head.size == size_t'(3)) begin
            check_equal(dreq.size, 2, "downstream size of wide read");
            check_equal(dreq.len, 2 * (int'(head.len) + 1) - 1, "downstream len of wide read");
          end else begin
            check_equal(dreq.size, head.size, "downstream size of narrow read");
            check_equal(dreq.len, head.len, "downstream len of narrow read");
          end
        end
        pend_q.push_back(dreq);
      end
      @(posedge clk_i);
      #1;
      if (r_taken) begin
        if (act_beat == int'(act_req.len)) begin
          act_on = 1'b0;
        end else begin
          act_beat++;
        end
      end
      if (!dn_r_valid_i || r_taken) begin
        if (!act_on && (pend_q.size() > 0)) begin
          pick  = $urandom_range(0, pend_q.size() - 1);
          first = pick;
          // Same id keeps its order
          for (int i = pick - 1; i >= 0; i--) begin
            if (pend_q[i].id == pend_q[pick].id) begin
              first = i;
            end
          end
          act_req  = pend_q[first];
          act_beat = 0;
          act_on   = 1'b1;
          pend_q.delete(first);
        end
        dn_r_valid_i = act_on && ($urandom_range(0, 3) != 0);
        if (act_on) begin
          dn_r_i = narrow_beat(act_req, act_beat);
        end
      end
      dn_ar_ready_i = ($urandom_range(0, 3) != 0);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MaxCycles) begin
      $display("Timeout: the reads did not finish within %0d cycles", MaxCycles);
      print_counts();
      $display("TEST FAIL");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: logic/ar_arbiter.sv
`default_nettype none

module ar_arbiter #(
  parameter int unsigned NumUnits = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [NumUnits-1:0]             unit_ar_valid_i,
  input  dwc_pkg::ar_req_t [NumUnits-1:0] unit_ar_i,
  output logic [NumUnits-1:0]             unit_ar_ready_o,
  output logic                            dn_ar_valid_o,
  output dwc_pkg::ar_req_t                dn_ar_o,
  input  logic                            dn_ar_ready_i
);

  localparam int unsigned IdxWidth = (NumUnits > 1) ? $clog2(NumUnits) : 1;

  // Last winner, held as the current choice while its request waits
  logic [IdxWidth-1:0] last_q;
  logic                locked_q;
  logic [IdxWidth-1:0] pick;
  logic [IdxWidth-1:0] sel;

  // First requester after the last winner, wrapping around
  always_comb begin
    int idx;
    pick = last_q;
    for (int k = NumUnits; k >= 1; k--) begin
      idx = (int'(last_q) + k) % NumUnits;
      if (unit_ar_valid_i[idx]) begin
        pick = IdxWidth'(idx);
      end
    end
  end

  assign sel           = locked_q ? last_q : pick;
  assign dn_ar_valid_o = unit_ar_valid_i[sel];
  assign dn_ar_o       = unit_ar_i[sel];

  always_comb begin
    for (int i = 0; i < NumUnits; i++) begin
      unit_ar_ready_o[i] = dn_ar_valid_o && dn_ar_ready_i && (sel == IdxWidth'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q   <= '0;
      locked_q <= 1'b0;
    end else if (dn_ar_valid_o) begin
      last_q   <= sel;
      locked_q <= !dn_ar_ready_i;
    end
  end

endmodule

`default_nettype wire

// File: logic/ar_dispatch.sv
`default_nettype none

module ar_dispatch #(
  parameter int unsigned NumUnits = 4
) (
  input  logic                         up_ar_valid_i,
  input  dwc_pkg::ar_req_t             up_ar_i,
  input  logic [NumUnits-1:0]          unit_busy_i,
  input  dwc_pkg::id_t [NumUnits-1:0]  unit_id_i,
  output logic                         up_ar_ready_o,
  output logic [NumUnits-1:0]          unit_grant_o
);

  localparam int unsigned IdxWidth = (NumUnits > 1) ? $clog2(NumUnits) : 1;

  logic [NumUnits-1:0] id_match;
  logic [IdxWidth-1:0] target_idx;

  // A busy unit already holding this id
  always_comb begin
    for (int i = 0; i < NumUnits; i++) begin
      id_match[i] = unit_busy_i[i] && (unit_id_i[i] == up_ar_i.id);
    end
  end

  always_comb begin
    target_idx = '0;
    // Lowest idle unit by default
    for (int i = NumUnits - 1; i >= 0; i--) begin
      if (!unit_busy_i[i]) begin
        target_idx = IdxWidth'(i);
      end
    end
    // Same id must queue behind the unit that holds it
    if (|id_match) begin
      for (int i = NumUnits - 1; i >= 0; i--) begin
        if (id_match[i]) begin
          target_idx = IdxWidth'(i);
        end
      end
    end
  end

  // Stall unless the target can take the request now
  assign up_ar_ready_o = !unit_busy_i[target_idx];

  always_comb begin
    for (int i = 0; i < NumUnits; i++) begin
      unit_grant_o[i] = up_ar_valid_i && up_ar_ready_o && (target_idx == IdxWidth'(i));
    end
  end

endmodule

`default_nettype wire

// File: logic/dw_read_downsizer.sv
`default_nettype none

module dw_read_downsizer #(
  parameter int unsigned NumUnits = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Wide upstream port
  input  logic             up_ar_valid_i,
  input  dwc_pkg::ar_req_t up_ar_i,
  output logic             up_ar_ready_o,
  output logic             up_r_valid_o,
  output dwc_pkg::up_r_t   up_r_o,
  input  logic             up_r_ready_i,
  // Narrow downstream port
  output logic             dn_ar_valid_o,
  output dwc_pkg::ar_req_t dn_ar_o,
  input  logic             dn_ar_ready_i,
  input  logic             dn_r_valid_i,
  input  dwc_pkg::dn_r_t   dn_r_i,
  output logic             dn_r_ready_o
);

  import dwc_pkg::*;

  logic    [NumUnits-1:0] unit_grant;
  logic    [NumUnits-1:0] unit_busy;
  id_t     [NumUnits-1:0] unit_id;
  logic    [NumUnits-1:0] unit_ar_valid;
  ar_req_t [NumUnits-1:0] unit_ar;
  logic    [NumUnits-1:0] unit_ar_ready;
  logic    [NumUnits-1:0] unit_dn_r_valid;
  logic    [NumUnits-1:0] unit_dn_r_ready;
  logic    [NumUnits-1:0] unit_up_r_valid;
  up_r_t   [NumUnits-1:0] unit_up_r;
  logic    [NumUnits-1:0] unit_up_r_grant;

  ar_dispatch #(
    .NumUnits (NumUnits)
  ) ar_dispatch_i (
    .up_ar_valid_i (up_ar_valid_i),
    .up_ar_i       (up_ar_i),
    .unit_busy_i   (unit_busy),
    .unit_id_i     (unit_id),
    .up_ar_ready_o (up_ar_ready_o),
    .unit_grant_o  (unit_grant)
  );

  for (genvar i = 0; i < NumUnits; i++) begin : gen_units
    read_unit read_unit_i (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .grant_i       (unit_grant[i]),
      .ar_i          (up_ar_i),
      .busy_o        (unit_busy[i]),
      .id_o          (unit_id[i]),
      .dn_ar_valid_o (unit_ar_valid[i]),
      .dn_ar_o       (unit_ar[i]),
      .dn_ar_ready_i (unit_ar_ready[i]),
      .dn_r_valid_i  (unit_dn_r_valid[i]),
      .dn_r_i        (dn_r_i),
      .dn_r_ready_o  (unit_dn_r_ready[i]),
      .up_r_valid_o  (unit_up_r_valid[i]),
      .up_r_o        (unit_up_r[i]),
      .up_r_grant_i  (unit_up_r_grant[i])
    );
  end

  ar_arbiter #(
    .NumUnits (NumUnits)
  ) ar_arbiter_i (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .unit_ar_valid_i (unit_ar_valid),
    .unit_ar_i       (unit_ar),
    .unit_ar_ready_o (unit_ar_ready),
    .dn_ar_valid_o   (dn_ar_valid_o),
    .dn_ar_o         (dn_ar_o),
    .dn_ar_ready_i   (dn_ar_ready_i)
  );

  r_router #(
    .NumUnits (NumUnits)
  ) r_router_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dn_r_valid_i      (dn_r_valid_i),
    .dn_r_i            (dn_r_i),
    .dn_r_ready_o      (dn_r_ready_o),
    .unit_busy_i       (unit_busy),
    .unit_id_i         (unit_id),
    .unit_dn_r_valid_o (unit_dn_r_valid),
    .unit_dn_r_ready_i (unit_dn_r_ready),
    .unit_up_r_valid_i (unit_up_r_valid),
    .unit_up_r_i       (unit_up_r),
    .unit_up_r_grant_o (unit_up_r_grant),
    .up_r_valid_o      (up_r_valid_o),
    .up_r_o            (up_r_o),
    .up_r_ready_i      (up_r_ready_i)
  );

endmodule

`default_nettype wire

// File: logic/r_router.sv
`default_nettype none

module r_router #(
  parameter int unsigned NumUnits = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          dn_r_valid_i,
  input  dwc_pkg::dn_r_t                dn_r_i,
  output logic                          dn_r_ready_o,
  input  logic [NumUnits-1:0]           unit_busy_i,
  input  dwc_pkg::id_t [NumUnits-1:0]   unit_id_i,
  output logic [NumUnits-1:0]           unit_dn_r_valid_o,
  input  logic [NumUnits-1:0]           unit_dn_r_ready_i,
  input  logic [NumUnits-1:0]           unit_up_r_valid_i,
  input  dwc_pkg::up_r_t [NumUnits-1:0] unit_up_r_i,
  output logic [NumUnits-1:0]           unit_up_r_grant_o,
  output logic                          up_r_valid_o,
  output dwc_pkg::up_r_t                up_r_o,
  input  logic                          up_r_ready_i
);

  localparam int unsigned IdxWidth = (NumUnits > 1) ? $clog2(NumUnits) : 1;

  logic [NumUnits-1:0] id_match;
  logic [IdxWidth-1:0] last_q;
  logic                locked_q;
  logic [IdxWidth-1:0] pick;
  logic [IdxWidth-1:0] sel;

  // Only one busy unit can hold a given id
  always_comb begin
    for (int i = 0; i < NumUnits; i++) begin
      id_match[i] = unit_busy_i[i] && (unit_id_i[i] == dn_r_i.id);
    end
  end

  assign unit_dn_r_valid_o = {NumUnits{dn_r_valid_i}} & id_match;
  assign dn_r_ready_o      = |(unit_dn_r_ready_i & id_match);

  // Upstream side, round-robin from the last winner
  always_comb begin
    int idx;
    pick = last_q;
    for (int k = NumUnits; k >= 1; k--) begin
      idx = (int'(last_q) + k) % NumUnits;
      if (unit_up_r_valid_i[idx]) begin
        pick = IdxWidth'(idx);
      end
    end
  end

  // Lock-in keeps a stalled winner selected
  assign sel          = locked_q ? last_q : pick;
  assign up_r_valid_o = unit_up_r_valid_i[sel];
  assign up_r_o       = unit_up_r_i[sel];

  always_comb begin
    for (int i = 0; i < NumUnits; i++) begin
      unit_up_r_grant_o[i] = up_r_valid_o && up_r_ready_i && (sel == IdxWidth'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q   <= '0;
      locked_q <= 1'b0;
    end else if (up_r_valid_o) begin
      last_q   <= sel;
      locked_q <= !up_r_ready_i;
    end
  end

endmodule

`default_nettype wire

// File: read_unit/read_unit.sv
`default_nettype none

module read_unit (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             grant_i,
  input  dwc_pkg::ar_req_t ar_i,
  output logic             busy_o,
  output dwc_pkg::id_t     id_o,
  output logic             dn_ar_valid_o,
  output dwc_pkg::ar_req_t dn_ar_o,
  input  logic             dn_ar_ready_i,
  input  logic             dn_r_valid_i,
  input  dwc_pkg::dn_r_t   dn_r_i,
  output logic             dn_r_ready_o,
  output logic             up_r_valid_o,
  output dwc_pkg::up_r_t   up_r_o,
  input  logic             up_r_grant_i
);

  import dwc_pkg::*;

  unit_state_e state_q;
  logic        ar_pending_q;
  logic        half_q;

  ar_req_t                  req_q;
  size_t                    orig_size_q;
  len_t                     beats_q;
  addr_t                    addr_q;
  logic [8*DnDataBytes-1:0] half_data_q;
  resp_e                    worst_q;

  logic                     to_downsize;
  logic                     first_half;
  logic                     up_hs;
  addr_t                    ar_addr_aligned;
  addr_t                    size_mask;
  resp_e                    dn_resp;
  logic [8*DnDataBytes-1:0] lane_data;

  assign busy_o        = (state_q != UNIT_IDLE);
  assign id_o          = req_q.id;
  assign dn_ar_valid_o = ar_pending_q;
  assign dn_ar_o       = req_q;

  assign to_downsize     = (ar_i.size == size_t'(UpMaxSize));
  assign ar_addr_aligned = ar_i.addr & ~((addr_t'(1) << ar_i.size) - addr_t'(1));
  assign size_mask       = (addr_t'(1) << orig_size_q) - addr_t'(1);
  assign dn_resp         = resp_e'(dn_r_i.resp);

  // Lower half of a pair, stored and acked without upstream
  assign first_half = (state_q == UNIT_DOWNSIZE) && !half_q;
  assign up_hs      = up_r_valid_o && up_r_grant_i;

  // Keep only the lanes the narrow transfer addresses
  always_comb begin
    lane_data = '0;
    for (int b = 0; b < DnDataBytes; b++) begin
      if ((b >= int'(addr_q[DnMaxSize-1:0])) &&
          (b < int'(addr_q[DnMaxSize-1:0]) + (1 << orig_size_q))) begin
        lane_data[8*b +: 8] = dn_r_i.data[8*b +: 8];
      end
    end
  end

  always_comb begin
    up_r_valid_o = 1'b0;
    dn_r_ready_o = 1'b0;
    up_r_o.id    = req_q.id;
    up_r_o.data  = '0;
    up_r_o.resp  = dn_r_i.resp;
    up_r_o.last  = (beats_q == '0);
    case (state_q)
      UNIT_PASSTHROUGH: begin
        up_r_valid_o = dn_r_valid_i;
        dn_r_ready_o = up_r_grant_i;
        // Address bit 2 picks the upper or lower word of the wide beat
        if (addr_q[DnMaxSize]) begin
          up_r_o.data = {lane_data, {(8*DnDataBytes){1'b0}}};
        end else begin
          up_r_o.data = {{(8*DnDataBytes){1'b0}}, lane_data};
        end
      end
      UNIT_DOWNSIZE: begin
        if (first_half) begin
          dn_r_ready_o = 1'b1;
        end else begin
          up_r_valid_o = dn_r_valid_i;
          dn_r_ready_o = up_r_grant_i;
          up_r_o.data  = {dn_r_i.data, half_data_q};
          // Report the worse of the two halves
          if (worst_q > dn_resp) begin
            up_r_o.resp = resp_t'(worst_q);
          end
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= UNIT_IDLE;
      ar_pending_q <= 1'b0;
      half_q       <= 1'b0;
    end else if (state_q == UNIT_IDLE) begin
      if (grant_i) begin
        state_q      <= to_downsize ? UNIT_DOWNSIZE : UNIT_PASSTHROUGH;
        ar_pending_q <= 1'b1;
      end
    end else begin
      if (ar_pending_q && dn_ar_ready_i) begin
        ar_pending_q <= 1'b0;
      end
      if (dn_r_valid_i && first_half) begin
        half_q <= 1'b1;
      end
      if (up_hs) begin
        half_q <= 1'b0;
        if (beats_q == '0) begin
          state_q <= UNIT_IDLE;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == UNIT_IDLE) && grant_i) begin
      req_q       <= ar_i;
      req_q.addr  <= ar_addr_aligned;
      orig_size_q <= ar_i.size;
      beats_q     <= ar_i.len;
      addr_q      <= ar_addr_aligned;
      // Twice as many narrow beats: 2*(len+1)-1
      if (to_downsize) begin
        req_q.len  <= {ar_i.len[6:0], 1'b1};
        req_q.size <= size_t'(DnMaxSize);
      end
    end
    if (dn_r_valid_i && first_half) begin
      half_data_q <= dn_r_i.data;
      worst_q     <= dn_resp;
    end
    if (up_hs) begin
      beats_q <= beats_q - len_t'(1);
      addr_q  <= (addr_q & ~size_mask) + size_mask + addr_t'(1);
    end
  end

endmodule

`default_nettype wire
